// ==== verilog/s2mm_config.svh ====
// Build-time parameters of the S2MM write engine
// Bus width, address width, burst limit and FIFO depth
`ifndef S2MM_CONFIG_SVH
`define S2MM_CONFIG_SVH

// Data bus
`define S2MM_DATA_W 32
`define S2MM_DATA_BYTES (`S2MM_DATA_W / 8)
`define S2MM_OFS_W $clog2(`S2MM_DATA_BYTES)

`define S2MM_ADDR_W 32

// Largest burst is 16 beats, awlen 15
`define S2MM_MAX_BEATS 16

// Power of two
`define S2MM_FIFO_DEPTH 16

`endif

// ==== verilog/s2mm_pkg.sv ====
// Shared types of the S2MM write engine
// FSM state encodings and the merged response code
`default_nettype none
`include "s2mm_config.svh"

package s2mm_pkg;

	typedef enum logic [1:0] {
		PLAN_IDLE,
		PLAN_SIZE,
		PLAN_ISSUE,
		PLAN_WAIT_DONE
	} plan_state_t;

	typedef enum logic [1:0] {
		ALIGN_IDLE,
		ALIGN_FETCH,
		ALIGN_FLUSH,
		ALIGN_DRAIN
	} align_state_t;

	// Result reported on the response port
	typedef enum logic [1:0] {
		RESP_NONE   = 2'd0,
		RESP_OKAY   = 2'd1,
		RESP_SLVERR = 2'd2,
		RESP_DECERR = 2'd3
	} resp_code_t;

endpackage

`default_nettype wire

// ==== verilog/s2mm_if.sv ====
// Internal interfaces of the S2MM write engine
// word_stream_if between FIFO and aligner, burst_if for burst events
`timescale 1ns/1ps
`default_nettype none
`include "s2mm_config.svh"

interface word_stream_if;
	logic [`S2MM_DATA_W-1:0] data;
	logic last;
	logic valid;
	logic ready;

	modport source(output data, last, valid, input ready);
	modport sink(input data, last, valid, output ready);
endinterface

interface burst_if;
	logic start;
	logic [7:0] len;
	logic done;
	logic final_burst;

	modport planner(output start, len, final_burst, input done);
	modport counter(input start, len, output done);
	modport monitor(input start, done, final_burst);
endinterface

`default_nettype wire

// ==== verilog/stream_fifo.sv ====
// Synchronous FIFO for the packed input stream
// Stores the last flag beside each data word
`timescale 1ns/1ps
`default_nettype none
`include "s2mm_config.svh"

module stream_fifo (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic [`S2MM_DATA_W-1:0] in_data,
	input  logic                    in_last,
	input  logic                    in_valid,
	output logic                    in_ready,
	word_stream_if.source           out
);
	localparam int W = `S2MM_DATA_W;
	localparam int DEPTH = `S2MM_FIFO_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);

	logic [W:0] mem [DEPTH];
	// Extra top bit tells a full buffer from an empty one
	logic [PTR_W:0] wr_ptr;
	logic [PTR_W:0] rd_ptr;
	logic full;
	logic push;
	logic pop;

	assign full = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
		(wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
	assign in_ready = !full;
	assign push = in_valid && !full;
	assign pop = out.valid && out.ready;

	assign out.valid = (wr_ptr != rd_ptr);
	assign out.data = mem[rd_ptr[PTR_W-1:0]][W-1:0];
	assign out.last = mem[rd_ptr[PTR_W-1:0]][W];

	always_ff @(posedge clk) begin
		if (push) begin
			mem[wr_ptr[PTR_W-1:0]] <= {in_last, in_data};
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/burst_planner.sv ====
// Burst planner FSM and AW channel driver
// Splits a transfer at the burst limit and at 4 KB boundaries
`timescale 1ns/1ps
`default_nettype none
`include "s2mm_config.svh"

module burst_planner (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    trigger,
	input  logic [`S2MM_ADDR_W-1:0] start_addr,
	input  logic [15:0]             bytes_to_write,
	input  logic                    all_resp_done,
	output logic                    busy,
	output logic [`S2MM_ADDR_W-1:0] awaddr,
	output logic [7:0]              awlen,
	output logic                    awvalid,
	input  logic                    awready,
	burst_if.planner                burst
);
	localparam int ADDR_W = `S2MM_ADDR_W;
	localparam int BYTES = `S2MM_DATA_BYTES;
	localparam int OFS_W = `S2MM_OFS_W;
	localparam int MAX_BEATS = `S2MM_MAX_BEATS;

	s2mm_pkg::plan_state_t state;
	logic [15:0] rem_q;
	logic final_q;
	logic [16:0] beats_left;
	logic [16:0] beats_4k;
	logic [16:0] beats_pick;
	logic [16:0] burst_bytes;
	logic [ADDR_W-1:0] next_addr;

	always_comb begin
		// Bus words touched by the remaining bytes
		beats_left = (17'(awaddr[OFS_W-1:0]) + 17'(rem_q) + 17'(BYTES - 1)) >> OFS_W;
		beats_4k = 17'(4096 / BYTES) - 17'(awaddr[11:OFS_W]);
		beats_pick = 17'(MAX_BEATS);
		if (beats_left < beats_pick) begin
			beats_pick = beats_left;
		end
		if (beats_4k < beats_pick) begin
			beats_pick = beats_4k;
		end
		burst_bytes = (17'(awlen) + 17'd1) << OFS_W;
		// Next burst starts word aligned
		next_addr = (awaddr & ~ADDR_W'(BYTES - 1)) + ADDR_W'(burst_bytes);
	end

	assign burst.start = awvalid && awready;
	assign burst.len = awlen;
	assign burst.final_burst = final_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= s2mm_pkg::PLAN_IDLE;
			busy <= 1'b0;
			awvalid <= 1'b0;
		end else begin
			case (state)
				s2mm_pkg::PLAN_IDLE: begin
					if (!busy && trigger) begin
						busy <= 1'b1;
						awaddr <= start_addr;
						rem_q <= bytes_to_write;
						if (bytes_to_write != 16'd0) begin
							state <= s2mm_pkg::PLAN_SIZE;
						end
					end else if (busy && all_resp_done) begin
						busy <= 1'b0;
					end
				end
				s2mm_pkg::PLAN_SIZE: begin
					awlen <= 8'(beats_pick - 17'd1);
					final_q <= (beats_pick == beats_left);
					state <= s2mm_pkg::PLAN_ISSUE;
				end
				s2mm_pkg::PLAN_ISSUE: begin
					if (!awvalid) begin
						awvalid <= 1'b1;
					end else if (awready) begin
						awvalid <= 1'b0;
						state <= s2mm_pkg::PLAN_WAIT_DONE;
					end
				end
				s2mm_pkg::PLAN_WAIT_DONE: begin
					if (burst.done) begin
						awaddr <= next_addr;
						rem_q <= rem_q - 16'(burst_bytes - 17'(awaddr[OFS_W-1:0]));
						state <= final_q ? s2mm_pkg::PLAN_IDLE : s2mm_pkg::PLAN_SIZE;
					end
				end
				default: begin
					state <= s2mm_pkg::PLAN_IDLE;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verilog/beat_counter.sv ====
// W beat counter for one burst
// Drives wlast and flags the end of the burst
`timescale 1ns/1ps
`default_nettype none
`include "s2mm_config.svh"

module beat_counter (
	input  logic     clk,
	input  logic     rst_n,
	burst_if.counter burst,
	input  logic     wvalid,
	input  logic     wready,
	output logic     wlast
);
	logic [7:0] cnt_q;
	logic open_q;
	logic w_hs;

	assign w_hs = wvalid && wready && open_q;
	assign wlast = open_q && (cnt_q == 8'd0);
	assign burst.done = w_hs && wlast;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt_q <= 8'd0;
			open_q <= 1'b0;
		end else begin
			if (burst.start) begin
				cnt_q <= burst.len;
				open_q <= 1'b1;
			end else if (w_hs) begin
				if (cnt_q == 8'd0) begin
					open_q <= 1'b0;
				end else begin
					cnt_q <= cnt_q - 8'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/write_aligner.sv ====
// Stream realignment to the start offset
// Builds byte strobes and drives the W data register
`timescale 1ns/1ps
`default_nettype none
`include "s2mm_config.svh"

module write_aligner (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        trigger,
	input  logic                        busy,
	input  logic [`S2MM_ADDR_W-1:0]     start_addr,
	input  logic [15:0]                 bytes_to_write,
	word_stream_if.sink                 stream,
	burst_if.monitor                    burst,
	output logic [`S2MM_DATA_W-1:0]     wdata,
	output logic [`S2MM_DATA_BYTES-1:0] wstrb,
	output logic                        wvalid,
	input  logic                        wready
);
	localparam int W = `S2MM_DATA_W;
	localparam int BYTES = `S2MM_DATA_BYTES;
	localparam int OFS_W = `S2MM_OFS_W;

	s2mm_pkg::align_state_t state;
	logic open_q;
	logic [OFS_W-1:0] ofs_q;
	// Byte positions relative to the word-aligned start
	logic [16:0] pos_q;
	logic [16:0] end_q;
	logic [W-1:0] prev_q;
	logic can_load;
	logic take_word;
	logic take_flush;
	logic [W-1:0] cur_word;
	logic [2*W-1:0] joined;
	logic [W-1:0] shifted;
	logic [BYTES-1:0] strb;
	logic [16:0] lane_pos;

	// No new word on the beat that closes a burst
	assign can_load = open_q && !burst.done && (!wvalid || wready);
	assign stream.ready = (state == s2mm_pkg::ALIGN_FETCH) && can_load;
	assign take_word = stream.ready && stream.valid;
	assign take_flush = (state == s2mm_pkg::ALIGN_FLUSH) && can_load;

	always_comb begin
		cur_word = (state == s2mm_pkg::ALIGN_FLUSH) ? '0 : stream.data;
		joined = {cur_word, prev_q};
		// Upper lanes from the new word, lower lanes carried over
		shifted = W'(joined >> (8 * (BYTES - int'(ofs_q))));
		lane_pos = pos_q;
		for (int l = 0; l < BYTES; l++) begin
			lane_pos = pos_q + 17'(l);
			strb[l] = (lane_pos >= 17'(ofs_q)) && (lane_pos < end_q);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= s2mm_pkg::ALIGN_IDLE;
			open_q <= 1'b0;
			wvalid <= 1'b0;
		end else begin
			if (burst.start) begin
				open_q <= 1'b1;
			end else if (burst.done) begin
				open_q <= 1'b0;
			end
			if (take_word || take_flush) begin
				wvalid <= 1'b1;
			end else if (wready) begin
				wvalid <= 1'b0;
			end
			case (state)
				s2mm_pkg::ALIGN_IDLE: begin
					if (trigger && !busy && bytes_to_write != 16'd0) begin
						state <= s2mm_pkg::ALIGN_FETCH;
					end
				end
				s2mm_pkg::ALIGN_FETCH: begin
					if (take_word && stream.last) begin
						// Carried bytes left over need one more word
						if (pos_q + 17'(BYTES) < end_q) begin
							state <= s2mm_pkg::ALIGN_FLUSH;
						end else begin
							state <= s2mm_pkg::ALIGN_DRAIN;
						end
					end
				end
				s2mm_pkg::ALIGN_FLUSH: begin
					if (take_flush) begin
						state <= s2mm_pkg::ALIGN_DRAIN;
					end
				end
				s2mm_pkg::ALIGN_DRAIN: begin
					if (burst.done && burst.final_burst) begin
						state <= s2mm_pkg::ALIGN_IDLE;
					end
				end
				default: begin
					state <= s2mm_pkg::ALIGN_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == s2mm_pkg::ALIGN_IDLE && trigger && !busy) begin
			ofs_q <= start_addr[OFS_W-1:0];
			end_q <= 17'(start_addr[OFS_W-1:0]) + 17'(bytes_to_write);
			pos_q <= 17'd0;
			prev_q <= '0;
		end
		if (take_word || take_flush) begin
			wdata <= shifted;
			wstrb <= strb;
			pos_q <= pos_q + 17'(BYTES);
		end
		if (take_word) begin
			prev_q <= stream.data;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/resp_collector.sv ====
// B channel handling
// Tracks outstanding responses and merges bresp into one result
`timescale 1ns/1ps
`default_nettype none
`include "s2mm_config.svh"

module resp_collector (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 trigger,
	input  logic                 busy,
	burst_if.monitor             burst,
	input  logic [1:0]           bresp,
	input  logic                 bvalid,
	output logic                 bready,
	output s2mm_pkg::resp_code_t response,
	output logic                 all_resp_done
);
	logic [15:0] issued_q;
	logic [15:0] recvd_q;
	logic b_hs;

	assign bready = (issued_q != recvd_q);
	assign b_hs = bvalid && bready;
	// Counts the response accepted in this cycle as well
	assign all_resp_done = (recvd_q + 16'(b_hs)) == issued_q;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			issued_q <= 16'd0;
			recvd_q <= 16'd0;
			response <= s2mm_pkg::RESP_NONE;
		end else if (trigger && !busy) begin
			issued_q <= 16'd0;
			recvd_q <= 16'd0;
			response <= s2mm_pkg::RESP_NONE;
		end else begin
			if (burst.start) begin
				issued_q <= issued_q + 16'd1;
			end
			if (b_hs) begin
				recvd_q <= recvd_q + 16'd1;
				// First error sticks
				if (response == s2mm_pkg::RESP_NONE || response == s2mm_pkg::RESP_OKAY) begin
					case (bresp)
						2'b00, 2'b01: response <= s2mm_pkg::RESP_OKAY;
						2'b10: response <= s2mm_pkg::RESP_SLVERR;
						default: response <= s2mm_pkg::RESP_DECERR;
					endcase
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== verilog/s2mm_top.sv ====
// Top level of the S2MM write engine
// AXI4 write master fed from a packed byte stream
`timescale 1ns/1ps
`default_nettype none
`include "s2mm_config.svh"

module s2mm_top (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        trigger,
	input  logic [`S2MM_ADDR_W-1:0]     start_addr,
	input  logic [15:0]                 bytes_to_write,
	output logic                        busy,
	output logic [1:0]                  response,

	output logic [`S2MM_ADDR_W-1:0]     m_axi_awaddr,
	output logic [7:0]                  m_axi_awlen,
	output logic [2:0]                  m_axi_awsize,
	output logic                        m_axi_awvalid,
	input  logic                        m_axi_awready,

	output logic [`S2MM_DATA_W-1:0]     m_axi_wdata,
	output logic [`S2MM_DATA_BYTES-1:0] m_axi_wstrb,
	output logic                        m_axi_wlast,
	output logic                        m_axi_wvalid,
	input  logic                        m_axi_wready,

	input  logic [1:0]                  m_axi_bresp,
	input  logic                        m_axi_bvalid,
	output logic                        m_axi_bready,

	input  logic [`S2MM_DATA_W-1:0]     s_axis_tdata,
	input  logic                        s_axis_tlast,
	input  logic                        s_axis_tvalid,
	output logic                        s_axis_tready
);
	logic all_resp_done;

	word_stream_if fifo_out ();
	burst_if burst ();

	// Every beat uses the full bus width
	assign m_axi_awsize = 3'(`S2MM_OFS_W);

	stream_fifo stream_fifo_i (
		.clk     (clk),
		.rst_n   (rst_n),
		.in_data (s_axis_tdata),
		.in_last (s_axis_tlast),
		.in_valid(s_axis_tvalid),
		.in_ready(s_axis_tready),
		.out     (fifo_out.source)
	);

	burst_planner burst_planner_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.trigger       (trigger),
		.start_addr    (start_addr),
		.bytes_to_write(bytes_to_write),
		.all_resp_done (all_resp_done),
		.busy          (busy),
		.awaddr        (m_axi_awaddr),
		.awlen         (m_axi_awlen),
		.awvalid       (m_axi_awvalid),
		.awready       (m_axi_awready),
		.burst         (burst.planner)
	);

	beat_counter beat_counter_i (
		.clk   (clk),
		.rst_n (rst_n),
		.burst (burst.counter),
		.wvalid(m_axi_wvalid),
		.wready(m_axi_wready),
		.wlast (m_axi_wlast)
	);

	write_aligner write_aligner_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.trigger       (trigger),
		.busy          (busy),
		.start_addr    (start_addr),
		.bytes_to_write(bytes_to_write),
		.stream        (fifo_out.sink),
		.burst         (burst.monitor),
		.wdata         (m_axi_wdata),
		.wstrb         (m_axi_wstrb),
		.wvalid        (m_axi_wvalid),
		.wready        (m_axi_wready)
	);

	resp_collector resp_collector_i (
		.clk          (clk),
		.rst_n        (rst_n),
		.trigger      (trigger),
		.busy         (busy),
		.burst        (burst.monitor),
		.bresp        (m_axi_bresp),
		.bvalid       (m_axi_bvalid),
		.bready       (m_axi_bready),
		.response     (response),
		.all_resp_done(all_resp_done)
	);

endmodule

`default_nettype wire

// ==== dv/s2mm_properties.sv ====
// AXI protocol assertions for the S2MM write engine
// Bound into s2mm_top
`timescale 1ns/1ps
`default_nettype none
`include "s2mm_config.svh"

module s2mm_properties (
	input logic                        clk,
	input logic                        rst_n,
	input logic [`S2MM_ADDR_W-1:0]     m_axi_awaddr,
	input logic [7:0]                  m_axi_awlen,
	input logic                        m_axi_awvalid,
	input logic                        m_axi_awready,
	input logic [`S2MM_DATA_W-1:0]     m_axi_wdata,
	input logic [`S2MM_DATA_BYTES-1:0] m_axi_wstrb,
	input logic                        m_axi_wlast,
	input logic                        m_axi_wvalid,
	input logic                        m_axi_wready,
	input logic                        m_axi_bready
);
	localparam int OFS_W = `S2MM_OFS_W;
	localparam int MAX_BEATS = `S2MM_MAX_BEATS;

	int fail_count = 0;
	logic [7:0] len_q;
	logic [7:0] beat_q;

	// Beat position inside the current W burst
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			len_q <= 8'd0;
			beat_q <= 8'd0;
		end else begin
			if (m_axi_awvalid && m_axi_awready) begin
				len_q <= m_axi_awlen;
			end
			if (m_axi_wvalid && m_axi_wready) begin
				beat_q <= m_axi_wlast ? 8'd0 : beat_q + 8'd1;
			end
		end
	end

	aw_stable: assert property (@(posedge clk) disable iff (!rst_n)
		m_axi_awvalid && !m_axi_awready |=>
		m_axi_awvalid && $stable(m_axi_awaddr) && $stable(m_axi_awlen))
	else begin
		fail_count = fail_count + 1;
		$error("AW payload changed or valid dropped before awready");
	end

	w_stable: assert property (@(posedge clk) disable iff (!rst_n)
		m_axi_wvalid && !m_axi_wready |=>
		m_axi_wvalid && $stable(m_axi_wdata) && $stable(m_axi_wstrb) && $stable(m_axi_wlast))
	else begin
		fail_count = fail_count + 1;
		$error("W payload changed or valid dropped before wready");
	end

	no_4k_cross: assert property (@(posedge clk) disable iff (!rst_n)
		m_axi_awvalid |->
		(13'(m_axi_awaddr[11:0] >> OFS_W) + 13'(m_axi_awlen)) < 13'(4096 >> OFS_W))
	else begin
		fail_count = fail_count + 1;
		$error("burst crosses a 4 KB boundary");
	end

	len_limit: assert property (@(posedge clk) disable iff (!rst_n)
		m_axi_awvalid |-> m_axi_awlen <= 8'(MAX_BEATS - 1))
	else begin
		fail_count = fail_count + 1;
		$error("awlen above the burst limit");
	end

	wlast_beat: assert property (@(posedge clk) disable iff (!rst_n)
		m_axi_wvalid && m_axi_wready |-> (m_axi_wlast == (beat_q == len_q)))
	else begin
		fail_count = fail_count + 1;
		$error("wlast not on beat awlen plus one");
	end

	bready_reset: assert property (@(posedge clk) !rst_n |=> !m_axi_bready)
	else begin
		fail_count = fail_count + 1;
		$error("bready high after reset");
	end

endmodule

bind s2mm_top s2mm_properties s2mm_properties_i (
	.clk          (clk),
	.rst_n        (rst_n),
	.m_axi_awaddr (m_axi_awaddr),
	.m_axi_awlen  (m_axi_awlen),
	.m_axi_awvalid(m_axi_awvalid),
	.m_axi_awready(m_axi_awready),
	.m_axi_wdata  (m_axi_wdata),
	.m_axi_wstrb  (m_axi_wstrb),
	.m_axi_wlast  (m_axi_wlast),
	.m_axi_wvalid (m_axi_wvalid),
	.m_axi_wready (m_axi_wready),
	.m_axi_bready (m_axi_bready)
);

`default_nettype wire

// ==== dv/s2mm_tb.sv ====
// Testbench for the S2MM write engine
// AXI slave memory model, stream source, transfer sequence and watchdog
`timescale 1ns/1ps
`default_nettype none
`include "s2mm_config.svh"

module s2mm_tb;
	localparam int W = `S2MM_DATA_W;
	localparam int BYTES = `S2MM_DATA_BYTES;
	localparam int AW = `S2MM_ADDR_W;
	localparam int CLK_PERIOD = 100;
	localparam int MEM_SIZE = 16384;
	// Slave answers SLVERR for bytes in this window
	localparam int ERR_LO = 'h3000;
	localparam int ERR_HI = 'h3100;
	localparam int TOTAL_BYTES = 64 + 39 + 150 + 101 + 200 + 80;
	localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 20 + 500;

	logic clk;
	logic rst_n;
	logic trigger;
	logic [AW-1:0] start_addr;
	logic [15:0] bytes_to_write;
	logic busy;
	logic [1:0] response;
	logic [AW-1:0] awaddr;
	logic [7:0] awlen;
	logic [2:0] awsize;
	logic awvalid;
	logic awready;
	logic [W-1:0] wdata;
	logic [BYTES-1:0] wstrb;
	logic wlast;
	logic wvalid;
	logic wready;
	logic [1:0] bresp;
	logic bvalid;
	logic bready;
	logic [W-1:0] tdata;
	logic tlast;
	logic tvalid;
	logic tready;

	logic [7:0] mem [MEM_SIZE];
	logic [7:0] exp_mem [MEM_SIZE];
	logic [W:0] stream_q [$];
	logic [AW-1:0] aw_q [$];
	logic [1:0] b_q [$];
	logic gaps;
	integer seed;
	int errors;

	s2mm_top s2mm_top_i (
		.clk           (clk),
		.rst_n         (rst_n),
		.trigger       (trigger),
		.start_addr    (start_addr),
		.bytes_to_write(bytes_to_write),
		.busy          (busy),
		.response      (response),
		.m_axi_awaddr  (awaddr),
		.m_axi_awlen   (awlen),
		.m_axi_awsize  (awsize),
		.m_axi_awvalid (awvalid),
		.m_axi_awready (awready),
		.m_axi_wdata   (wdata),
		.m_axi_wstrb   (wstrb),
		.m_axi_wlast   (wlast),
		.m_axi_wvalid  (wvalid),
		.m_axi_wready  (wready),
		.m_axi_bresp   (bresp),
		.m_axi_bvalid  (bvalid),
		.m_axi_bready  (bready),
		.s_axis_tdata  (tdata),
		.s_axis_tlast  (tlast),
		.s_axis_tvalid (tvalid),
		.s_axis_tready (tready)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [7:0] fill_byte(input int a);
		return 8'(a ^ (a >> 8) ^ 'h5a);
	endfunction

	// Slave memory model and stream source sampling handshakes mid-cycle
	initial begin : bus_model
		logic aw_fire;
		logic w_fire;
		logic b_fire;
		logic t_fire;
		logic [AW-1:0] aw_addr_s;
		logic [2:0] aw_size_s;
		logic [W-1:0] wdata_s;
		logic [BYTES-1:0] wstrb_s;
		logic wlast_s;
		logic [AW-1:0] w_addr;
		logic w_open;
		logic w_err;
		int a;
		awready = 1'b0;
		wready = 1'b0;
		bresp = 2'b00;
		bvalid = 1'b0;
		tdata = '0;
		tlast = 1'b0;
		tvalid = 1'b0;
		w_addr = '0;
		w_open = 1'b0;
		w_err = 1'b0;
		forever begin
			@(negedge clk);
			aw_fire = awvalid && awready;
			w_fire = wvalid && wready;
			b_fire = bvalid && bready;
			t_fire = tvalid && tready;
			aw_addr_s = awaddr;
			aw_size_s = awsize;
			wdata_s = wdata;
			wstrb_s = wstrb;
			wlast_s = wlast;
			@(posedge clk);
			#1;
			if (aw_fire) begin
				aw_q.push_back(aw_addr_s);
				assert (aw_size_s === 3'($clog2(BYTES))) else begin
					$display("mismatch awsize expected %h actual %h", 3'($clog2(BYTES)),
						aw_size_s);
					errors++;
				end
			end
			if (w_fire) begin
				if (!w_open) begin
					// Beats use address-aligned byte lanes
					w_addr = aw_q.pop_front() & ~AW'(BYTES - 1);
					w_open = 1'b1;
					w_err = 1'b0;
				end
				for (int i = 0; i < BYTES; i++) begin
					if (wstrb_s[i]) begin
						a = int'(w_addr) + i;
						mem[a % MEM_SIZE] = wdata_s[8*i +: 8];
						if (a >= ERR_LO && a < ERR_HI) begin
							w_err = 1'b1;
						end
					end
				end
				w_addr = w_addr + AW'(BYTES);
				if (wlast_s) begin
					b_q.push_back(w_err ? 2'b10 : 2'b00);
					w_open = 1'b0;
				end
			end
			if (b_fire) begin
				void'(b_q.pop_front());
			end
			bvalid = (b_q.size() != 0);
			bresp = bvalid ? b_q[0] : 2'b00;
			if (t_fire) begin
				void'(stream_q.pop_front());
			end
			// A word once offered stays until taken
			if (!(tvalid && !t_fire)) begin
				tvalid = (stream_q.size() != 0) && (!gaps || (($random(seed) & 3) != 0));
			end
			if (tvalid) begin
				tdata = stream_q[0][W-1:0];
				tlast = stream_q[0][W];
			end
			awready = !gaps || (($random(seed) & 1) != 0);
			wready = !gaps || (($random(seed) & 1) != 0);
		end
	end

	task automatic load_transfer(input logic [AW-1:0] addr, input int len, input int tnum);
		logic [W:0] word;
		word = '0;
		for (int i = 0; i < len; i++) begin
			exp_mem[(int'(addr) + i) % MEM_SIZE] = 8'(i + tnum);
			word[8*(i % BYTES) +: 8] = 8'(i + tnum);
			if ((i % BYTES) == BYTES - 1 || i == len - 1) begin
				word[W] = (i == len - 1);
				stream_q.push_back(word);
				word = '0;
			end
		end
		@(posedge clk);
		#1;
		start_addr = addr;
		bytes_to_write = 16'(len);
		trigger = 1'b1;
		@(posedge clk);
		#1;
		trigger = 1'b0;
	endtask

	task automatic check_memory;
		for (int a = 0; a < MEM_SIZE; a++) begin
			assert (mem[a] === exp_mem[a]) else begin
				$display("mismatch mem[%h] expected %h actual %h", a, exp_mem[a], mem[a]);
				errors++;
			end
		end
	endtask

	task automatic finish_transfer(input int tnum, input logic [1:0] exp_resp);
		@(negedge clk);
		assert (busy === 1'b1) else begin
			$display("transfer %0d did not raise busy after trigger", tnum);
			errors++;
		end
		while (busy === 1'b1) begin
			@(negedge clk);
		end
		assert (response === exp_resp) else begin
			$display("mismatch response expected %h actual %h", exp_resp, response);
			errors++;
		end
		check_memory();
	endtask

	initial begin : stimulus
		seed = 32'hbf79e926;
		errors = 0;
		gaps = 1'b0;
		rst_n = 1'b0;
		trigger = 1'b0;
		start_addr = '0;
		bytes_to_write = 16'd0;
		for (int a = 0; a < MEM_SIZE; a++) begin
			mem[a] = fill_byte(a);
			exp_mem[a] = fill_byte(a);
		end
		repeat (2) @(posedge clk);
		#1;
		rst_n = 1'b1;
		@(negedge clk);
		assert (busy === 1'b0) else begin
			$display("mismatch busy expected 0 actual %h", busy);
			errors++;
		end
		assert (response === 2'(s2mm_pkg::RESP_NONE)) else begin
			$display("mismatch response expected %h actual %h", 2'd0, response);
			errors++;
		end

		// Aligned, whole words
		load_transfer('h100, 64, 0);
		finish_transfer(0, 2'(s2mm_pkg::RESP_OKAY));
		// Unaligned head and odd tail needing the flush word
		load_transfer('h203, 39, 1);
		finish_transfer(1, 2'(s2mm_pkg::RESP_OKAY));
		// Several bursts across the 4 KB line
		load_transfer('hfc6, 150, 2);
		finish_transfer(2, 2'(s2mm_pkg::RESP_OKAY));
		gaps = 1'b1;
		load_transfer('h1a01, 101, 3);
		finish_transfer(3, 2'(s2mm_pkg::RESP_OKAY));
		gaps = 1'b0;
		load_transfer('h2f80, 200, 4);
		finish_transfer(4, 2'(s2mm_pkg::RESP_SLVERR));

		// Second trigger while busy must be ignored
		load_transfer('h500, 80, 5);
		while (awvalid !== 1'b1) begin
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		start_addr = 'h700;
		bytes_to_write = 16'd16;
		trigger = 1'b1;
		@(posedge clk);
		#1;
		trigger = 1'b0;
		finish_transfer(5, 2'(s2mm_pkg::RESP_OKAY));
		repeat (4) @(negedge clk);
		assert (busy === 1'b0) else begin
			$display("a trigger while busy started a second transfer");
			errors++;
		end
		check_memory();

		$display("checks done: %0d errors, %0d assertion failures", errors,
			s2mm_top_i.s2mm_properties_i.fail_count);
		if (errors == 0 && s2mm_top_i.s2mm_properties_i.fail_count == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

	initial begin : watchdog
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout: transfers did not complete in %0d cycles", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+verilog
verilog/s2mm_pkg.sv
verilog/s2mm_if.sv
verilog/stream_fifo.sv
verilog/burst_planner.sv
verilog/beat_counter.sv
verilog/write_aligner.sv
verilog/resp_collector.sv
verilog/s2mm_top.sv
dv/s2mm_properties.sv
dv/s2mm_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build with Verilator, run, and scan the log for the fail message
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module s2mm_tb -f build.f \
	&& ./obj_dir/Vs2mm_tb +verilator+error+limit+1000 > sim.log 2>&1 \
	&& ! grep -q "TEST RESULT: FAIL" sim.log \
	&& grep -q "TEST RESULT: PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed, see sim.log"; exit 1; }
